//--- src/bsx_pkg.sv
`default_nettype none

package bsx_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;
  typedef logic [7:0]  reg_byte_t;
  typedef logic [15:0] flash_addr_t;
  typedef logic [4:0]  base_index_t;
  typedef logic [14:0] map_regs_t;

  // sec, min, hour, day, month, year, century from bit 0 up
  typedef logic [55:0] rtc_bcd_t;

  typedef enum logic [1:0] {
    flash_idle,
    flash_unlock1,
    flash_unlock2
  } flash_state_t;

  ////////////////////////////////////////////////////////////
  // Reset values and fixed bytes
  ////////////////////////////////////////////////////////////

  localparam map_regs_t MAP_REGS_RESET = 15'h0100;

  localparam base_index_t BASE_FIRST = 5'h08;
  localparam base_index_t BASE_LAST  = 5'h1f;

  localparam reg_byte_t BASE_RESET_0B = 8'h9f;
  localparam reg_byte_t BASE_RESET_0C = 8'h10;
  localparam reg_byte_t BASE_RESET_11 = 8'h9f;
  localparam reg_byte_t BASE_RESET_12 = 8'h01;
  localparam reg_byte_t BASE_RESET_16 = 8'h02;
  localparam reg_byte_t BASE_RESET_17 = 8'hff;
  localparam reg_byte_t BASE_RESET_18 = 8'h80;
  localparam reg_byte_t BASE_RESET_19 = 8'h01;

  // Reads of 2192 per packet before wrap
  localparam logic [4:0] STREAM_LEN = 5'd18;

  // Byte 0 at FF00
  localparam logic [7:0][7:0] FLASH_VENDOR_ID = {
    8'h00, 8'h2a, 8'h00, 8'h00, 8'h00, 8'h50, 8'h00, 8'h4d
  };

  localparam reg_byte_t FLASH_STATUS_READY = 8'h80;

endpackage

`default_nettype wire

//--- src/bsx_bus_interface.sv
`timescale 1ns/100ps
`default_nettype none

module bsx_bus_interface (
  input  wire                 clkin,
  input  wire                 rst_n,
  input  wire                 reg_oe,
  input  wire                 reg_we,
  input  wire                 pgm_we,
  input  wire                 use_bsx,
  input  bsx_pkg::snes_addr_t snes_addr,
  input  wire                 flash_override,
  input  bsx_pkg::reg_byte_t  cart_rd_data,
  input  bsx_pkg::reg_byte_t  base_rd_data,
  input  bsx_pkg::reg_byte_t  stream_rd_data,
  input  bsx_pkg::reg_byte_t  flash_rd_data,
  output logic                cart_sel,
  output logic                base_sel,
  output logic                flash_sel,
  output logic                rd_cart,
  output logic                rd_base,
  output logic                rd_flash,
  output logic                wr_cart,
  output logic                wr_base,
  output logic                wr_flash,
  output logic                pgm_strobe,
  output logic                data_ovr,
  output bsx_pkg::reg_byte_t  reg_data_out
);

  logic [3:0] oe_sreg;
  logic [1:0] we_sreg;
  logic [1:0] pgm_sreg;
  logic       oe_falling;
  logic       we_rising;
  logic       pgm_rising;
  logic       wr_ok;
  bsx_pkg::base_index_t base_index;

  ////////////////////////////////////////////////////////////
  // Strobe synchronisers
  ////////////////////////////////////////////////////////////

  // Console strobes idle high
  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      oe_sreg  <= 4'b1111;
      we_sreg  <= 2'b11;
      pgm_sreg <= 2'b11;
    end else begin
      oe_sreg  <= {oe_sreg[2:0], reg_oe};
      we_sreg  <= {we_sreg[0], reg_we};
      pgm_sreg <= {pgm_sreg[0], pgm_we};
    end
  end

  assign oe_falling = (oe_sreg == 4'b1000);
  assign we_rising  = (we_sreg == 2'b01);
  assign pgm_rising = (pgm_sreg == 2'b01);

  ////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////

  assign base_index = snes_addr[4:0];

  // Banks 00-0F, offset 5000-5FFF
  assign cart_sel  = use_bsx && ((snes_addr[23:12] & 12'hf0f) == 12'h005);
  assign base_sel  = use_bsx && !snes_addr[22]
                     && (snes_addr[15:0] >= 16'h2188) && (snes_addr[15:0] <= 16'h219f);
  assign flash_sel = use_bsx && (snes_addr[23:16] == 8'hc0);

  assign data_ovr = cart_sel | base_sel | flash_override;

  // Read wins over MCU programming, which wins over a console write
  assign rd_cart  = oe_falling && cart_sel;
  assign rd_base  = oe_falling && !cart_sel && base_sel;
  assign rd_flash = oe_falling && !cart_sel && !base_sel && flash_sel;

  assign pgm_strobe = pgm_rising && !oe_falling;
  assign wr_ok      = we_rising && !oe_falling && !pgm_rising;

  assign wr_cart  = wr_ok && cart_sel;
  assign wr_base  = wr_ok && !cart_sel && base_sel;
  assign wr_flash = wr_ok && !cart_sel && !base_sel && flash_sel;

  // Read data register
  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      reg_data_out <= '0;
    end else if (rd_cart) begin
      reg_data_out <= cart_rd_data;
    end else if (rd_base) begin
      reg_data_out <= (base_index == 5'h12) ? stream_rd_data : base_rd_data;
    end else if (rd_flash) begin
      reg_data_out <= flash_rd_data;
    end
  end

endmodule

`default_nettype wire

//--- src/bsx_flash_cmd_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module bsx_flash_cmd_fsm (
  input  wire                  clkin,
  input  wire                  rst_n,
  input  wire                  flash_sel,
  input  wire                  wr_flash,
  input  bsx_pkg::flash_addr_t flash_addr,
  input  bsx_pkg::reg_byte_t   reg_data_in,
  output logic                 flash_override,
  output logic                 flash_writable,
  output bsx_pkg::reg_byte_t   flash_rd_data
);

  bsx_pkg::flash_state_t state_q;
  bsx_pkg::flash_state_t state_d;
  bsx_pkg::reg_byte_t    cmd0_q;
  logic                  ovr_q;
  logic                  we_q;
  logic                  special;

  // Unlock sequence AA@5555, 55@2AAA
  always_comb begin
    state_d = bsx_pkg::flash_idle;
    case (state_q)
      bsx_pkg::flash_idle,
      bsx_pkg::flash_unlock2: begin
        if (flash_addr == 16'h5555 && reg_data_in == 8'haa)
          state_d = bsx_pkg::flash_unlock1;
      end
      bsx_pkg::flash_unlock1: begin
        if (flash_addr == 16'h2aaa && reg_data_in == 8'h55)
          state_d = bsx_pkg::flash_unlock2;
        else if (flash_addr == 16'h5555 && reg_data_in == 8'haa)
          state_d = bsx_pkg::flash_unlock1;
      end
      default: state_d = bsx_pkg::flash_idle;
    endcase
  end

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= bsx_pkg::flash_idle;
      cmd0_q  <= '0;
      ovr_q   <= 1'b0;
      we_q    <= 1'b0;
    end else if (wr_flash) begin
      state_q <= state_d;
      if (state_q == bsx_pkg::flash_unlock2 && flash_addr == 16'h5555) begin
        case (reg_data_in)
          8'hf0: begin
            ovr_q <= 1'b0;
            we_q  <= 1'b0;
          end
          8'ha0: begin
            ovr_q <= 1'b1;
            we_q  <= 1'b1;
          end
          8'h70: we_q <= 1'b0;
          default: ;
        endcase
      end
      // Override unlock on 0000
      if (flash_addr == 16'h0000) begin
        cmd0_q <= reg_data_in;
        if (cmd0_q == 8'h38 && reg_data_in == 8'hd0)
          ovr_q <= 1'b1;
      end
    end
  end

  assign special = (flash_addr == 16'h0000) || (flash_addr == 16'h0002)
                   || (flash_addr == 16'h2aaa) || (flash_addr == 16'h5555)
                   || (flash_addr >= 16'hff00 && flash_addr <= 16'hff13);

  assign flash_override = flash_sel && ovr_q && special;
  assign flash_writable = flash_sel && we_q && !special;

  always_comb begin
    if (flash_addr == 16'h0002 || flash_addr == 16'h5555)
      flash_rd_data = bsx_pkg::FLASH_STATUS_READY;
    else if (flash_addr[15:3] == 13'h1fe0)
      flash_rd_data = bsx_pkg::FLASH_VENDOR_ID[flash_addr[2:0]];
    else
      flash_rd_data = '0;
  end

endmodule

`default_nettype wire

//--- src/bsx_stream_counter.sv
`timescale 1ns/100ps
`default_nettype none

module bsx_stream_counter (
  input  wire                clkin,
  input  wire                rst_n,
  input  wire                rd_stream,
  input  wire                clr_stream,
  input  bsx_pkg::rtc_bcd_t  rtc_data,
  output bsx_pkg::reg_byte_t stream_rd_data
);

  logic [4:0]         pos_q;
  bsx_pkg::reg_byte_t rtc_sec;
  bsx_pkg::reg_byte_t rtc_min;
  bsx_pkg::reg_byte_t rtc_hour;

  function automatic bsx_pkg::reg_byte_t bcd_to_bin(input logic [7:0] bcd);
    return ({4'd0, bcd[7:4]} * 8'd10) + {4'd0, bcd[3:0]};
  endfunction

  assign rtc_sec  = bcd_to_bin(rtc_data[7:0]);
  assign rtc_min  = bcd_to_bin(rtc_data[15:8]);
  assign rtc_hour = bcd_to_bin(rtc_data[23:16]);

  ////////////////////////////////////////////////////////////
  // Packet position
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      pos_q <= '0;
    end else if (clr_stream) begin
      pos_q <= '0;
    end else if (rd_stream) begin
      // One read past the end returns 0 and restarts
      if (pos_q < bsx_pkg::STREAM_LEN)
        pos_q <= pos_q + 5'd1;
      else
        pos_q <= '0;
    end
  end

  always_comb begin
    case (pos_q)
      5'd5, 5'd6: stream_rd_data = 8'h01;
      5'd10:      stream_rd_data = rtc_sec;
      5'd11:      stream_rd_data = rtc_min;
      5'd12:      stream_rd_data = rtc_hour;
      default:    stream_rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/bsx_base_regs.sv
`timescale 1ns/100ps
`default_nettype none

module bsx_base_regs (
  input  wire                  clkin,
  input  wire                  rst_n,
  input  wire                  rd_base,
  input  wire                  wr_base,
  input  bsx_pkg::base_index_t base_index,
  input  bsx_pkg::reg_byte_t   reg_data_in,
  output bsx_pkg::reg_byte_t   base_rd_data,
  output logic                 rd_stream,
  output logic                 clr_stream
);

  bsx_pkg::reg_byte_t regs_q [bsx_pkg::BASE_FIRST:bsx_pkg::BASE_LAST];

  function automatic bsx_pkg::reg_byte_t reset_value(input bsx_pkg::base_index_t idx);
    case (idx)
      5'h0b, 5'h0d: return bsx_pkg::BASE_RESET_0B;
      5'h0c:        return bsx_pkg::BASE_RESET_0C;
      5'h11:        return bsx_pkg::BASE_RESET_11;
      5'h12:        return bsx_pkg::BASE_RESET_12;
      5'h16:        return bsx_pkg::BASE_RESET_16;
      5'h17:        return bsx_pkg::BASE_RESET_17;
      5'h18:        return bsx_pkg::BASE_RESET_18;
      5'h19:        return bsx_pkg::BASE_RESET_19;
      default:      return 8'h00;
    endcase
  endfunction

  // 2191 restarts the stream, 2192 reads it
  assign rd_stream  = rd_base && (base_index == 5'h12);
  assign clr_stream = wr_base && (base_index == 5'h11);

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = int'(bsx_pkg::BASE_FIRST); i <= int'(bsx_pkg::BASE_LAST); i++)
        regs_q[i] <= reset_value(bsx_pkg::base_index_t'(i));
    end else if (wr_base && base_index >= bsx_pkg::BASE_FIRST) begin
      case (base_index)
        5'h0f: begin
          regs_q[5'h0e] <= regs_q[5'h0f] - (regs_q[5'h0e] >> 1);
          regs_q[5'h0f] <= regs_q[5'h0f] >> 1;
        end
        5'h12: regs_q[5'h10] <= 8'h80;
        default: regs_q[base_index] <= reg_data_in;
      endcase
    end
  end

  always_comb begin
    if (base_index < bsx_pkg::BASE_FIRST)
      base_rd_data = '0;
    else if (base_index == 5'h13)
      base_rd_data = regs_q[base_index] & 8'h3f;
    else
      base_rd_data = regs_q[base_index];
  end

endmodule

`default_nettype wire

//--- src/bsx_cart_regs.sv
`timescale 1ns/100ps
`default_nettype none

module bsx_cart_regs (
  input  wire                clkin,
  input  wire                rst_n,
  input  wire                wr_cart,
  input  wire                pgm_strobe,
  input  wire [3:0]          reg_index,
  input  bsx_pkg::reg_byte_t reg_data_in,
  input  bsx_pkg::reg_byte_t reg_set_bits,
  input  bsx_pkg::reg_byte_t reg_reset_bits,
  output bsx_pkg::map_regs_t regs_out,
  output bsx_pkg::reg_byte_t cart_rd_data
);

  bsx_pkg::map_regs_t staged_q;
  bsx_pkg::map_regs_t live_q;

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      staged_q <= bsx_pkg::MAP_REGS_RESET;
      live_q   <= bsx_pkg::MAP_REGS_RESET;
    end else if (pgm_strobe) begin
      // MCU set mask applied before the clear mask
      staged_q[8:1] <= (staged_q[8:1] | reg_set_bits) & ~reg_reset_bits;
      live_q[8:1]   <= (live_q[8:1] | reg_set_bits) & ~reg_reset_bits;
    end else if (wr_cart) begin
      if (reg_index == 4'he && reg_data_in[7])
        live_q <= staged_q | 15'h4000;
      else if (reg_index != 4'hf)
        staged_q[reg_index] <= reg_data_in[7];
    end
  end

  assign regs_out = live_q;

  // Index F has no mapping bit and reads as 0
  always_comb begin
    if (reg_index == 4'hf)
      cart_rd_data = '0;
    else
      cart_rd_data = {live_q[reg_index], 7'b0};
  end

endmodule

`default_nettype wire

//--- src/bsx_top.sv
`timescale 1ns/100ps
`default_nettype none

module bsx_top (
  input  wire                 clkin,
  input  wire                 rst_n,
  input  wire                 reg_oe,
  input  wire                 reg_we,
  input  wire                 pgm_we,
  input  wire                 use_bsx,
  input  bsx_pkg::snes_addr_t snes_addr,
  input  bsx_pkg::reg_byte_t  reg_data_in,
  input  bsx_pkg::reg_byte_t  reg_set_bits,
  input  bsx_pkg::reg_byte_t  reg_reset_bits,
  input  bsx_pkg::rtc_bcd_t   rtc_data,
  output bsx_pkg::reg_byte_t  reg_data_out,
  output bsx_pkg::map_regs_t  regs_out,
  output logic                data_ovr,
  output logic                flash_writable
);

  logic               flash_sel;
  logic               rd_base;
  logic               wr_cart;
  logic               wr_base;
  logic               wr_flash;
  logic               pgm_strobe;
  logic               flash_override;
  logic               rd_stream;
  logic               clr_stream;
  bsx_pkg::reg_byte_t cart_rd_data;
  bsx_pkg::reg_byte_t base_rd_data;
  bsx_pkg::reg_byte_t stream_rd_data;
  bsx_pkg::reg_byte_t flash_rd_data;

  bsx_bus_interface u_bus (
    .clkin          (clkin),
    .rst_n          (rst_n),
    .reg_oe         (reg_oe),
    .reg_we         (reg_we),
    .pgm_we         (pgm_we),
    .use_bsx        (use_bsx),
    .snes_addr      (snes_addr),
    .flash_override (flash_override),
    .cart_rd_data   (cart_rd_data),
    .base_rd_data   (base_rd_data),
    .stream_rd_data (stream_rd_data),
    .flash_rd_data  (flash_rd_data),
    .cart_sel       (),
    .base_sel       (),
    .flash_sel      (flash_sel),
    .rd_cart        (),
    .rd_base        (rd_base),
    .rd_flash       (),
    .wr_cart        (wr_cart),
    .wr_base        (wr_base),
    .wr_flash       (wr_flash),
    .pgm_strobe     (pgm_strobe),
    .data_ovr       (data_ovr),
    .reg_data_out   (reg_data_out)
  );

  bsx_flash_cmd_fsm u_flash (
    .clkin          (clkin),
    .rst_n          (rst_n),
    .flash_sel      (flash_sel),
    .wr_flash       (wr_flash),
    .flash_addr     (snes_addr[15:0]),
    .reg_data_in    (reg_data_in),
    .flash_override (flash_override),
    .flash_writable (flash_writable),
    .flash_rd_data  (flash_rd_data)
  );

  bsx_stream_counter u_stream (
    .clkin          (clkin),
    .rst_n          (rst_n),
    .rd_stream      (rd_stream),
    .clr_stream     (clr_stream),
    .rtc_data       (rtc_data),
    .stream_rd_data (stream_rd_data)
  );

  bsx_base_regs u_base (
    .clkin        (clkin),
    .rst_n        (rst_n),
    .rd_base      (rd_base),
    .wr_base      (wr_base),
    .base_index   (snes_addr[4:0]),
    .reg_data_in  (reg_data_in),
    .base_rd_data (base_rd_data),
    .rd_stream    (rd_stream),
    .clr_stream   (clr_stream)
  );

  bsx_cart_regs u_cart (
    .clkin          (clkin),
    .rst_n          (rst_n),
    .wr_cart        (wr_cart),
    .pgm_strobe     (pgm_strobe),
    .reg_index      (snes_addr[19:16]),
    .reg_data_in    (reg_data_in),
    .reg_set_bits   (reg_set_bits),
    .reg_reset_bits (reg_reset_bits),
    .regs_out       (regs_out),
    .cart_rd_data   (cart_rd_data)
  );

endmodule

`default_nettype wire

//--- testbench/bsx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module bsx_tb;

  logic                clkin;
  logic                rst_n;
  logic                reg_oe;
  logic                reg_we;
  logic                pgm_we;
  logic                use_bsx;
  bsx_pkg::snes_addr_t snes_addr;
  bsx_pkg::reg_byte_t  reg_data_in;
  bsx_pkg::reg_byte_t  reg_set_bits;
  bsx_pkg::reg_byte_t  reg_reset_bits;
  bsx_pkg::rtc_bcd_t   rtc_data;
  bsx_pkg::reg_byte_t  reg_data_out;
  bsx_pkg::map_regs_t  regs_out;
  logic                data_ovr;
  logic                flash_writable;

  logic [31:0] lcg_state;
  string       test_name;
  int          test_checks = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          total_checks = 0;
  int          total_errors = 0;

  bsx_top dut0 (
    .clkin          (clkin),
    .rst_n          (rst_n),
    .reg_oe         (reg_oe),
    .reg_we         (reg_we),
    .pgm_we         (pgm_we),
    .use_bsx        (use_bsx),
    .snes_addr      (snes_addr),
    .reg_data_in    (reg_data_in),
    .reg_set_bits   (reg_set_bits),
    .reg_reset_bits (reg_reset_bits),
    .rtc_data       (rtc_data),
    .reg_data_out   (reg_data_out),
    .regs_out       (regs_out),
    .data_ovr       (data_ovr),
    .flash_writable (flash_writable)
  );

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  ////////////////////////////////////////////////////////////
  // Timing and bus tasks
  ////////////////////////////////////////////////////////////

  // Inputs change 2 ns after the rising edge
  task automatic tick();
    @(posedge clkin);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    for (int k = 0; k < n; k++)
      tick();
  endtask

  task automatic set_addr(input bsx_pkg::snes_addr_t addr);
    snes_addr = addr;
    tick();
  endtask

  task automatic bus_read(input bsx_pkg::snes_addr_t addr, output bsx_pkg::reg_byte_t data);
    snes_addr = addr;
    reg_oe = 1'b0;
    wait_cycles(8);
    data = reg_data_out;
    reg_oe = 1'b1;
    wait_cycles(8);
  endtask

  // Write lands on the rising edge of reg_we
  task automatic bus_write(input bsx_pkg::snes_addr_t addr, input bsx_pkg::reg_byte_t data);
    snes_addr = addr;
    reg_data_in = data;
    reg_we = 1'b0;
    wait_cycles(8);
    reg_we = 1'b1;
    wait_cycles(8);
  endtask

  task automatic pgm_pulse(input bsx_pkg::reg_byte_t set, input bsx_pkg::reg_byte_t clr);
    reg_set_bits = set;
    reg_reset_bits = clr;
    pgm_we = 1'b0;
    wait_cycles(8);
    pgm_we = 1'b1;
    wait_cycles(8);
  endtask

  ////////////////////////////////////////////////////////////
  // Expected values and bookkeeping
  ////////////////////////////////////////////////////////////

  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:23];
  endfunction

  function automatic logic [7:0] bcd_pair(input logic [7:0] hi_limit);
    logic [7:0] hi;
    logic [7:0] lo;
    hi = lcg_byte() % hi_limit;
    lo = lcg_byte() % 8'd10;
    return {hi[3:0], lo[3:0]};
  endfunction

  function automatic logic [7:0] to_binary(input logic [7:0] bcd);
    return 8'(bcd[7:4]) * 8'd10 + 8'(bcd[3:0]);
  endfunction

  function automatic logic [7:0] stream_byte(input int pos, input bsx_pkg::rtc_bcd_t rtc);
    case (pos)
      5, 6:    return 8'h01;
      10:      return to_binary(rtc[7:0]);
      11:      return to_binary(rtc[15:8]);
      12:      return to_binary(rtc[23:16]);
      default: return 8'h00;
    endcase
  endfunction

  function automatic logic [7:0] base_reset(input logic [4:0] idx);
    case (idx)
      5'h0b, 5'h0d, 5'h11: return 8'h9f;
      5'h0c:               return 8'h10;
      5'h12, 5'h19:        return 8'h01;
      5'h16:               return 8'h02;
      5'h17:               return 8'hff;
      5'h18:               return 8'h80;
      default:             return 8'h00;
    endcase
  endfunction

  function automatic logic [7:0] vendor_byte(input logic [2:0] idx);
    case (idx)
      3'd0:    return 8'h4d;
      3'd2:    return 8'h50;
      3'd6:    return 8'h2a;
      default: return 8'h00;
    endcase
  endfunction

  function automatic bsx_pkg::snes_addr_t cart_addr(input logic [3:0] idx);
    return {4'h0, idx, 16'h5000};
  endfunction

  function automatic bsx_pkg::snes_addr_t base_addr(input logic [4:0] idx);
    return 24'h002180 | {19'd0, idx};
  endfunction

  task automatic check_value(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
    test_checks++;
    assert (actual === expected) else begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %s %0d checks, %0d errors", test_name, test_checks, test_errors);
    tests_run++;
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  // Index 13 reads back only its low 6 bits
  task automatic check_base(input logic [4:0] idx, input bsx_pkg::reg_byte_t value);
    bsx_pkg::reg_byte_t data;
    bus_read(base_addr(idx), data);
    check_value($sformatf("base %h", idx), 16'((idx == 5'h13) ? (value & 8'h3f) : value),
                16'(data));
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_test();
    start_test("reset");
    set_addr(24'h008000);
    check_value("regs_out", 16'h0100, 16'(regs_out));
    check_value("flash_writable", 16'd0, 16'(flash_writable));
    check_value("data_ovr outside", 16'd0, 16'(data_ovr));
    check_value("reg_data_out", 16'd0, 16'(reg_data_out));
    set_addr(24'hc01234);
    check_value("data_ovr c0:1234", 16'd0, 16'(data_ovr));
    use_bsx = 1'b0;
    set_addr(24'h005000);
    check_value("no bsx 5000", 16'd0, 16'(data_ovr));
    set_addr(24'h002190);
    check_value("no bsx 2190", 16'd0, 16'(data_ovr));
    set_addr(24'hc00000);
    check_value("no bsx c0:0000", 16'd0, 16'(data_ovr));
    use_bsx = 1'b1;
    end_test();
  endtask

  task automatic cart_test();
    bsx_pkg::map_regs_t staged;
    bsx_pkg::map_regs_t live;
    bsx_pkg::reg_byte_t data;
    bsx_pkg::reg_byte_t set;
    bsx_pkg::reg_byte_t clr;
    start_test("cart");
    staged = 15'h0100;
    for (int i = 0; i < 14; i++) begin
      data = lcg_byte();
      bus_write(cart_addr(i[3:0]), data);
      staged[i[3:0]] = data[7];
    end
    check_value("before commit", 16'h0100, 16'(regs_out));
    bus_write(cart_addr(4'he), 8'h80);
    live = staged | 15'h4000;
    check_value("commit", 16'(live), 16'(regs_out));
    for (int i = 0; i < 15; i++) begin
      bus_read(cart_addr(i[3:0]), data);
      check_value($sformatf("read %h", i[3:0]), 16'({live[i[3:0]], 7'b0}), 16'(data));
    end
    set = lcg_byte();
    clr = lcg_byte();
    pgm_pulse(set, clr);
    live[8:1] = (live[8:1] | set) & ~clr;
    check_value("pgm masks", 16'(live), 16'(regs_out));
    end_test();
  endtask

  task automatic base_test();
    bsx_pkg::reg_byte_t model [8:31];
    bsx_pkg::reg_byte_t data;
    bsx_pkg::reg_byte_t old_0e;
    start_test("base");
    // 2192 is the stream port, not the register
    for (int i = 8; i < 32; i++) begin
      model[i[4:0]] = base_reset(i[4:0]);
      if (i != 'h12)
        check_base(i[4:0], model[i[4:0]]);
    end
    for (int i = 8; i < 32; i++) begin
      if (i != 'h0f && i != 'h12) begin
        data = lcg_byte();
        bus_write(base_addr(i[4:0]), data);
        model[i[4:0]] = data;
      end
    end
    for (int i = 8; i < 32; i++) begin
      if (i != 'h12)
        check_base(i[4:0], model[i[4:0]]);
    end
    bus_write(base_addr(5'h0f), lcg_byte());
    old_0e = model[5'h0e];
    model[5'h0e] = model[5'h0f] - (old_0e >> 1);
    model[5'h0f] = model[5'h0f] >> 1;
    check_base(5'h0e, model[5'h0e]);
    check_base(5'h0f, model[5'h0f]);
    bus_write(base_addr(5'h12), lcg_byte());
    check_base(5'h10, 8'h80);
    end_test();
  endtask

  task automatic stream_test();
    bsx_pkg::rtc_bcd_t  rtc;
    bsx_pkg::reg_byte_t data;
    start_test("stream");
    rtc[7:0] = bcd_pair(8'd6);
    rtc[15:8] = bcd_pair(8'd6);
    rtc[23:16] = bcd_pair(8'd3);
    for (int b = 3; b < 7; b++)
      rtc[b * 8 +: 8] = bcd_pair(8'd10);
    rtc_data = rtc;
    // Move off position 0 so the restart shows
    for (int p = 0; p < 3; p++)
      bus_read(24'h002192, data);
    bus_write(24'h002191, lcg_byte());
    for (int p = 0; p < 18; p++) begin
      bus_read(24'h002192, data);
      check_value($sformatf("pos %0d", p), 16'(stream_byte(p, rtc)), 16'(data));
    end
    bus_read(24'h002192, data);
    check_value("read 19", 16'd0, 16'(data));
    // Packet starts over after the wrap
    for (int p = 0; p < 7; p++) begin
      bus_read(24'h002192, data);
      check_value($sformatf("wrap pos %0d", p), 16'(stream_byte(p, rtc)), 16'(data));
    end
    end_test();
  endtask

  task automatic flash_test();
    bsx_pkg::reg_byte_t data;
    start_test("flash");
    bus_write(24'hc05555, 8'haa);
    bus_write(24'hc02aaa, 8'h55);
    bus_write(24'hc05555, 8'ha0);
    set_addr(24'hc01234);
    check_value("writable 1234", 16'd1, 16'(flash_writable));
    check_value("ovr 1234", 16'd0, 16'(data_ovr));
    set_addr(24'hc05555);
    check_value("writable 5555", 16'd0, 16'(flash_writable));
    check_value("ovr 5555", 16'd1, 16'(data_ovr));
    for (int i = 0; i < 8; i++) begin
      bus_read(24'hc0ff00 | {21'd0, i[2:0]}, data);
      check_value($sformatf("vendor %0d", i), 16'(vendor_byte(i[2:0])), 16'(data));
    end
    bus_read(24'hc00002, data);
    check_value("status 0002", 16'h0080, 16'(data));
    bus_write(24'hc05555, 8'haa);
    bus_write(24'hc02aaa, 8'h55);
    bus_write(24'hc05555, 8'hf0);
    set_addr(24'hc01234);
    check_value("cleared writable", 16'd0, 16'(flash_writable));
    set_addr(24'hc05555);
    check_value("cleared ovr", 16'd0, 16'(data_ovr));
    bus_write(24'hc00000, 8'h38);
    bus_write(24'hc00000, 8'hd0);
    set_addr(24'hc00000);
    check_value("ovr after d0", 16'd1, 16'(data_ovr));
    set_addr(24'hc01234);
    check_value("writable after d0", 16'd0, 16'(flash_writable));
    // Override flag is set here, so only use_bsx can hold data_ovr low
    use_bsx = 1'b0;
    set_addr(24'hc00000);
    check_value("no bsx ovr", 16'd0, 16'(data_ovr));
    use_bsx = 1'b1;
    end_test();
  endtask

  initial begin
    lcg_state = 32'd45;
    rst_n = 1'b0;
    reg_oe = 1'b1;
    reg_we = 1'b1;
    pgm_we = 1'b1;
    use_bsx = 1'b1;
    snes_addr = '0;
    reg_data_in = '0;
    reg_set_bits = '0;
    reg_reset_bits = '0;
    rtc_data = '0;
    wait_cycles(8);
    rst_n = 1'b1;
    tick();

    reset_test();
    cart_test();
    base_test();
    stream_test();
    flash_test();

    $display("Tests %0d, checks %0d, errors %0d", tests_run, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bsx_top.f
src/bsx_pkg.sv
src/bsx_bus_interface.sv
src/bsx_flash_cmd_fsm.sv
src/bsx_stream_counter.sv
src/bsx_base_regs.sv
src/bsx_cart_regs.sv
src/bsx_top.sv
testbench/bsx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench and RTL with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bsx_tb -Mdir obj_dir -f bsx_top.f

./obj_dir/Vbsx_tb | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "Run passed"
  exit 0
fi

echo "Run failed, see sim.log"
exit 1
